// ==== design/rename_pkg.sv ====
package rename_pkg;

    // architectural register file
    localparam int NUM_AREGS = 32;
    localparam int AREG_W    = 5;

    // reorder buffer
    localparam int ROB_DEPTH = 64;
    localparam int ROB_W     = 6;

    // instructions per decode bundle
    localparam int RENAME_WIDTH = 2;

    // architectural register id
    typedef logic [AREG_W-1:0] arf_id_t;

    // reorder buffer id, wraps modulo ROB_DEPTH
    typedef logic [ROB_W-1:0] rob_id_t;

    // occupancy needs one extra bit to hold a full ROB
    typedef logic [ROB_W:0] rob_cnt_t;

    // alias table entry
    // bit ROB_W is the mapping valid flag, low bits hold the producer id
    typedef logic [ROB_W:0] rat_entry_t;

endpackage

// ==== design/rename_ifs.sv ====
// alias table access between the rename stage and the table
interface rat_port_if;
    import rename_pkg::*;

    // four source lookups, two per instruction
    arf_id_t    [2*RENAME_WIDTH-1:0] raddr;
    rat_entry_t [2*RENAME_WIDTH-1:0] rdata;

    // one destination update per instruction
    arf_id_t    [RENAME_WIDTH-1:0]   waddr;
    logic       [RENAME_WIDTH-1:0]   we;
    rob_id_t    [RENAME_WIDTH-1:0]   wdata;

    modport stage (
        output raddr,
        input  rdata,
        output waddr,
        output we,
        output wdata
    );

    modport tbl (
        input  raddr,
        output rdata,
        input  waddr,
        input  we,
        input  wdata
    );

endinterface

// ROB id allocation between the rename stage and the allocator
interface rob_alloc_if;
    import rename_pkg::*;

    // one bit per slot taking an id this cycle
    logic    [RENAME_WIDTH-1:0] alloc;
    // candidate ids for slot 0 and slot 1
    rob_id_t [RENAME_WIDTH-1:0] ids;
    // room for a full bundle
    logic                       space_ok;

    modport stage (
        output alloc,
        input  ids,
        input  space_ok
    );

    modport allocator (
        input  alloc,
        output ids,
        output space_ok
    );

endinterface

// ==== design/rename_rat.sv ====
module rename_rat (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       flush_i,
    rat_port_if.tbl    rat
);
    import rename_pkg::*;

    // mapping flags, cleared by reset and flush
    logic    [NUM_AREGS-1:0] vld_q;
    // producer ids, only meaningful where the flag is set
    rob_id_t                 rob_q [NUM_AREGS];

    // asynchronous lookups
    always_comb begin
        for (int r = 0; r < 2*RENAME_WIDTH; r++) begin
            rat.rdata[r] = {vld_q[rat.raddr[r]], rob_q[rat.raddr[r]]};
        end
    end

    // valid flags
    // later port is assigned last so the younger instruction wins
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else if (flush_i) begin
            vld_q <= '0;
        end else begin
            for (int w = 0; w < RENAME_WIDTH; w++) begin
                if (rat.we[w]) begin
                    vld_q[rat.waddr[w]] <= 1'b1;
                end
            end
        end
    end

    // producer ids
    always_ff @(posedge clk) begin
        for (int w = 0; w < RENAME_WIDTH; w++) begin
            if (rat.we[w] && !flush_i) begin
                rob_q[rat.waddr[w]] <= rat.wdata[w];
            end
        end
    end

endmodule

// ==== design/rob_alloc.sv ====
module rob_alloc (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic [rename_pkg::RENAME_WIDTH-1:0] retire_i,
    rob_alloc_if.allocator                      rob
);
    import rename_pkg::*;

    rob_id_t  tail_q;
    rob_id_t  tail_nxt;
    rob_cnt_t occ_q;
    rob_cnt_t occ_nxt;
    rob_cnt_t n_alloc;
    rob_cnt_t n_retire;

    // slot 1 skips past slot 0 only when slot 0 takes an id
    assign rob.ids[0] = tail_q;
    assign rob.ids[1] = rob.alloc[0] ? tail_q + rob_id_t'(1) : tail_q;

    // leave room for a whole bundle
    assign rob.space_ok = (occ_q <= rob_cnt_t'(ROB_DEPTH - RENAME_WIDTH));

    always_comb begin
        n_alloc  = '0;
        n_retire = '0;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            n_alloc  = n_alloc + rob_cnt_t'(rob.alloc[s]);
            n_retire = n_retire + rob_cnt_t'(retire_i[s]);
        end
        // tail wraps by plain overflow of the id width
        tail_nxt = tail_q + rob_id_t'(n_alloc);
        occ_nxt  = occ_q + n_alloc - n_retire;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tail_q <= '0;
            occ_q  <= '0;
        end else if (flush_i) begin
            // rewind allocation
            tail_q <= '0;
            occ_q  <= '0;
        end else begin
            tail_q <= tail_nxt;
            occ_q  <= occ_nxt;
        end
    end

endmodule

// ==== design/rename_stage.sv ====
module rename_stage (
    input  logic                                                  clk,
    input  logic                                                  rst_n_i,
    input  logic                                                  flush_i,
    // decode side
    input  logic                                                  in_valid_i,
    output logic                                                  in_ready_o,
    input  logic                [rename_pkg::RENAME_WIDTH-1:0]    in_slot_valid_i,
    input  rename_pkg::arf_id_t [2*rename_pkg::RENAME_WIDTH-1:0]  in_src_i,
    input  rename_pkg::arf_id_t [rename_pkg::RENAME_WIDTH-1:0]    in_dst_i,
    // dispatch side
    output logic                                                  out_valid_o,
    input  logic                                                  out_ready_i,
    output logic                [rename_pkg::RENAME_WIDTH-1:0]    out_slot_valid_o,
    output rename_pkg::rat_entry_t [2*rename_pkg::RENAME_WIDTH-1:0] out_src_map_o,
    output rename_pkg::rob_id_t [rename_pkg::RENAME_WIDTH-1:0]    out_dst_rob_o,
    // table and allocator
    rat_port_if.stage                                             rat,
    rob_alloc_if.stage                                            rob
);
    import rename_pkg::*;

    logic                              xfer;
    logic [RENAME_WIDTH-1:0]           take;
    logic                              dst0_named;
    rat_entry_t [2*RENAME_WIDTH-1:0]   src_map;

    logic                              out_valid_q;
    logic [RENAME_WIDTH-1:0]           slot_valid_q;
    rat_entry_t [2*RENAME_WIDTH-1:0]   src_map_q;
    rob_id_t    [RENAME_WIDTH-1:0]     dst_rob_q;

    // handshake
    // output slot is free when empty or draining this cycle
    assign in_ready_o = rob.space_ok & ~flush_i & (~out_valid_q | out_ready_i);
    assign xfer       = in_valid_i & in_ready_o;

    // every valid slot of an accepted bundle takes an id
    assign take      = in_slot_valid_i & {RENAME_WIDTH{xfer}};
    assign rob.alloc = take;

    // table lookups
    assign rat.raddr = in_src_i;

    // table updates, r0 never gets a mapping
    assign rat.waddr = in_dst_i;
    assign rat.wdata = rob.ids;
    always_comb begin
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            rat.we[s] = take[s] & (in_dst_i[s] != '0);
        end
    end

    // bypass inside the bundle
    // slot 1 sources are indices 2 and 3 and see slot 0's fresh id
    assign dst0_named = in_slot_valid_i[0] & (in_dst_i[0] != '0);

    always_comb begin
        src_map = rat.rdata;
        for (int r = RENAME_WIDTH; r < 2*RENAME_WIDTH; r++) begin
            if (dst0_named && (in_src_i[r] == in_dst_i[0])) begin
                src_map[r] = {1'b1, rob.ids[0]};
            end
        end
    end

    // output register control
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q  <= 1'b0;
            slot_valid_q <= '0;
        end else if (flush_i) begin
            out_valid_q  <= 1'b0;
            slot_valid_q <= '0;
        end else if (xfer) begin
            out_valid_q  <= 1'b1;
            slot_valid_q <= in_slot_valid_i;
        end else if (out_ready_i) begin
            // drained with nothing behind it
            out_valid_q  <= 1'b0;
        end
    end

    // output payload, held while dispatch stalls
    always_ff @(posedge clk) begin
        if (xfer) begin
            src_map_q <= src_map;
            dst_rob_q <= rob.ids;
        end
    end

    assign out_valid_o      = out_valid_q;
    assign out_slot_valid_o = slot_valid_q;
    assign out_src_map_o    = src_map_q;
    assign out_dst_rob_o    = dst_rob_q;

endmodule

// ==== design/rename_top.sv ====
module rename_top (
    input  logic                                                    clk,
    input  logic                                                    rst_n_i,
    // decode side
    input  logic                                                    in_valid_i,
    output logic                                                    in_ready_o,
    input  logic                  [rename_pkg::RENAME_WIDTH-1:0]    in_slot_valid_i,
    input  rename_pkg::arf_id_t   [2*rename_pkg::RENAME_WIDTH-1:0]  in_src_i,
    input  rename_pkg::arf_id_t   [rename_pkg::RENAME_WIDTH-1:0]    in_dst_i,
    // dispatch side
    output logic                                                    out_valid_o,
    input  logic                                                    out_ready_i,
    output logic                  [rename_pkg::RENAME_WIDTH-1:0]    out_slot_valid_o,
    output rename_pkg::rat_entry_t [2*rename_pkg::RENAME_WIDTH-1:0] out_src_map_o,
    output rename_pkg::rob_id_t   [rename_pkg::RENAME_WIDTH-1:0]    out_dst_rob_o,
    // commit side
    input  logic                  [rename_pkg::RENAME_WIDTH-1:0]    retire_i,
    input  logic                                                    flush_i
);

    rat_port_if  u_rat_if ();
    rob_alloc_if u_rob_if ();

    // handshake, bypass and output register
    rename_stage u_rename_stage (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .in_slot_valid_i  (in_slot_valid_i),
        .in_src_i         (in_src_i),
        .in_dst_i         (in_dst_i),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_slot_valid_o (out_slot_valid_o),
        .out_src_map_o    (out_src_map_o),
        .out_dst_rob_o    (out_dst_rob_o),
        .rat              (u_rat_if.stage),
        .rob              (u_rob_if.stage)
    );

    // register alias table
    rename_rat u_rename_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .rat     (u_rat_if.tbl)
    );

    // ROB tail and occupancy
    rob_alloc u_rob_alloc (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .retire_i (retire_i),
        .rob      (u_rob_if.allocator)
    );

endmodule

// ==== verification/rename_checker.sv ====
module rename_checker (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                in_ready_i,
    input  logic                                out_valid_i,
    input  logic                                out_ready_i,
    input  logic [1:0]                          out_slot_valid_i,
    input  rename_pkg::rat_entry_t [3:0]        out_src_map_i,
    input  rename_pkg::rob_id_t [1:0]           out_dst_rob_i,
    input  rename_pkg::rob_cnt_t                occ_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import rename_pkg::*;

    // stalled output holds its payload
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_valid_i && !out_ready_i && !flush_i) |=>
            (out_valid_i && $stable(out_slot_valid_i) && $stable(out_src_map_i)
             && $stable(out_dst_rob_i)))
        else $error("output changed while dispatch stalled");

    a_no_ready_on_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |-> !in_ready_i)
        else $error("in_ready_o high during flush");

    a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        occ_i <= rob_cnt_t'(ROB_DEPTH))
        else $error("ROB occupancy above depth");

    // ids of a full bundle are consecutive
    a_ids_consecutive: assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_valid_i && out_ready_i && out_slot_valid_i == 2'b11) |->
            (out_dst_rob_i[1] == rob_id_t'(out_dst_rob_i[0] + 6'd1)))
        else $error("slot 1 id does not follow slot 0 id");

endmodule

bind rename_top rename_checker u_rename_checker (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .in_ready_i       (in_ready_o),
    .out_valid_i      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .out_slot_valid_i (out_slot_valid_o),
    .out_src_map_i    (out_src_map_o),
    .out_dst_rob_i    (out_dst_rob_o),
    .occ_i            (u_rob_alloc.occ_q)
);

// ==== verification/tb_rename_top.sv ====
module tb_rename_top;
    timeunit 1ns;
    timeprecision 100ps;
    import rename_pkg::*;

    // one row of the stimulus table
    typedef struct packed {
        logic                in_valid;
        logic [1:0]          slot_valid;
        arf_id_t [3:0]       src;
        arf_id_t [1:0]       dst;
        logic                out_ready;
        logic [1:0]          retire;
        logic                flush;
    } step_t;

    // expected contents of the output register
    typedef struct packed {
        logic [1:0]          slot_valid;
        rat_entry_t [3:0]    src_map;
        rob_id_t [1:0]       dst_rob;
    } exp_t;

    logic                    clk;
    logic                    rst_n_i;
    logic                    in_valid_i;
    logic                    in_ready_o;
    logic [1:0]              in_slot_valid_i;
    arf_id_t [3:0]           in_src_i;
    arf_id_t [1:0]           in_dst_i;
    logic                    out_valid_o;
    logic                    out_ready_i;
    logic [1:0]              out_slot_valid_o;
    rat_entry_t [3:0]        out_src_map_o;
    rob_id_t [1:0]           out_dst_rob_o;
    logic [1:0]              retire_i;
    logic                    flush_i;

    step_t                   steps[$];
    exp_t                    exp_q[$];
    logic                    table_ready;
    int                      seed;
    int                      errors;
    logic                    full_seen;

    // reference model state
    rat_entry_t              shadow [NUM_AREGS];
    rob_id_t                 m_tail;
    int                      m_occ;
    logic                    m_out_valid;

    rename_top u_rename_top (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .in_slot_valid_i  (in_slot_valid_i),
        .in_src_i         (in_src_i),
        .in_dst_i         (in_dst_i),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_slot_valid_o (out_slot_valid_o),
        .out_src_map_o    (out_src_map_o),
        .out_dst_rob_o    (out_dst_rob_o),
        .retire_i         (retire_i),
        .flush_i          (flush_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, act, exp);
        end
    endtask

    function automatic int ones(input logic [1:0] v);
        return int'(v[0]) + int'(v[1]);
    endfunction

    function automatic arf_id_t rand_reg();
        return arf_id_t'($random(seed));
    endfunction

    task automatic add_step(input logic iv, input logic [1:0] sv,
                            input arf_id_t s0, input arf_id_t s1,
                            input arf_id_t s2, input arf_id_t s3,
                            input arf_id_t d0, input arf_id_t d1,
                            input logic ordy, input logic [1:0] ret, input logic fl);
        step_t st;
        st.in_valid   = iv;
        st.slot_valid = sv;
        st.src        = {s3, s2, s1, s0};
        st.dst        = {d1, d0};
        st.out_ready  = ordy;
        st.retire     = ret;
        st.flush      = fl;
        steps.push_back(st);
    endtask

    // output register against the oldest expected bundle
    task automatic compare_output(input exp_t e);
        int idx;
        check_eq("out_slot_valid_o", 32'(out_slot_valid_o), 32'(e.slot_valid));
        for (int s = 0; s < 2; s++) begin
            if (e.slot_valid[s]) begin
                check_eq($sformatf("out_dst_rob_o[%0d]", s), 32'(out_dst_rob_o[s]),
                         32'(e.dst_rob[s]));
                for (int j = 0; j < 2; j++) begin
                    idx = 2*s + j;
                    // producer id only matters for a live mapping
                    if (e.src_map[idx][ROB_W]) begin
                        check_eq($sformatf("out_src_map_o[%0d]", idx),
                                 32'(out_src_map_o[idx]), 32'(e.src_map[idx]));
                    end else begin
                        check_eq($sformatf("out_src_map_o[%0d].valid", idx),
                                 32'(out_src_map_o[idx][ROB_W]), 32'(1'b0));
                    end
                end
            end
        end
    endtask

    // predicts the coming edge from the inputs that are now stable
    task automatic model_cycle(input step_t st);
        logic    exp_ready;
        exp_t    e;
        rob_id_t id0;
        rob_id_t id1;
        exp_ready = (m_occ <= ROB_DEPTH - RENAME_WIDTH) && !st.flush
                    && (!m_out_valid || st.out_ready);
        check_eq("in_ready_o", 32'(in_ready_o), 32'(exp_ready));
        check_eq("out_valid_o", 32'(out_valid_o), 32'(m_out_valid));
        if (st.in_valid && m_occ > ROB_DEPTH - RENAME_WIDTH && !in_ready_o) full_seen = 1'b1;
        if (m_out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output register valid with no bundle expected at %0t", $time);
            end else begin
                compare_output(exp_q[0]);
                if (st.out_ready) void'(exp_q.pop_front());
            end
        end
        if (st.flush) begin
            for (int r = 0; r < NUM_AREGS; r++) shadow[r] = '0;
            m_tail      = '0;
            m_occ       = 0;
            m_out_valid = 1'b0;
            exp_q.delete();
        end else begin
            if (st.in_valid && exp_ready) begin
                id0          = m_tail;
                id1          = st.slot_valid[0] ? m_tail + 6'd1 : m_tail;
                e.slot_valid = st.slot_valid;
                e.dst_rob    = {id1, id0};
                for (int i = 0; i < 4; i++) e.src_map[i] = shadow[st.src[i]];
                // slot 1 sees the fresh mapping of slot 0
                for (int i = 2; i < 4; i++) begin
                    if (st.slot_valid[0] && st.dst[0] != '0 && st.src[i] == st.dst[0])
                        e.src_map[i] = {1'b1, id0};
                end
                if (st.slot_valid[0] && st.dst[0] != '0) shadow[st.dst[0]] = {1'b1, id0};
                if (st.slot_valid[1] && st.dst[1] != '0) shadow[st.dst[1]] = {1'b1, id1};
                m_tail = m_tail + rob_id_t'(ones(st.slot_valid));
                m_occ  = m_occ + ones(st.slot_valid);
                exp_q.push_back(e);
                m_out_valid = 1'b1;
            end else if (st.out_ready) begin
                m_out_valid = 1'b0;
            end
            m_occ = m_occ - ones(st.retire);
        end
    endtask

    task automatic build_table();
        add_step(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
        add_step(1, 3, 1, 2, 3, 4, 5, 6, 1, 0, 0);
        add_step(1, 3, 5, 6, 1, 7, 7, 8, 1, 0, 0);
        // r0 destination and a bypass candidate reading r0
        add_step(1, 3, 7, 8, 0, 8, 0, 8, 1, 0, 0);
        // r0 read back in a valid slot
        add_step(1, 3, 8, 0, 9, 8, 9, 9, 1, 0, 0);
        add_step(1, 1, 9, 5, 0, 0, 10, 0, 1, 0, 0);
        add_step(1, 2, 0, 0, 10, 9, 0, 11, 1, 0, 0);
        // dispatch stalls, then drains
        add_step(1, 3, 11, 10, 5, 6, 12, 13, 0, 0, 0);
        add_step(1, 3, 12, 13, 1, 2, 14, 15, 0, 0, 0);
        add_step(1, 3, 12, 13, 1, 2, 14, 15, 0, 0, 0);
        add_step(1, 3, 12, 13, 1, 2, 14, 15, 1, 0, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
        // flush with a bundle offered
        add_step(1, 3, 5, 7, 8, 9, 1, 2, 1, 0, 1);
        add_step(1, 3, 5, 7, 8, 9, 1, 2, 1, 0, 0);
        // fill the ROB up to 63 entries
        for (int i = 0; i < 30; i++)
            add_step(1, 3, rand_reg(), rand_reg(), rand_reg(), rand_reg(),
                     rand_reg(), rand_reg(), 1, 0, 0);
        add_step(1, 1, rand_reg(), 3, 4, 5, rand_reg(), 6, 1, 0, 0);
        for (int i = 0; i < 3; i++)
            add_step(1, 3, rand_reg(), rand_reg(), 1, 2, 3, 4, 1, 0, 0);
        // retire frees room and the tail wraps
        for (int i = 0; i < 24; i++)
            add_step(1, 2'($random(seed)), rand_reg(), rand_reg(), rand_reg(), rand_reg(),
                     rand_reg(), rand_reg(), 1'($random(seed)), 2'b11, 0);
        for (int i = 0; i < 3; i++) add_step(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
    endtask

    initial begin
        seed            = 32'h5f7f983b;
        errors          = 0;
        full_seen       = 1'b0;
        table_ready     = 1'b0;
        rst_n_i         = 1'b0;
        in_valid_i      = 1'b0;
        in_slot_valid_i = '0;
        in_src_i        = '0;
        in_dst_i        = '0;
        out_ready_i     = 1'b0;
        retire_i        = '0;
        flush_i         = 1'b0;
        m_tail          = '0;
        m_occ           = 0;
        m_out_valid     = 1'b0;
        for (int r = 0; r < NUM_AREGS; r++) shadow[r] = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        foreach (steps[i]) begin
            @(posedge clk);
            in_valid_i      <= steps[i].in_valid;
            in_slot_valid_i <= steps[i].slot_valid;
            in_src_i        <= steps[i].src;
            in_dst_i        <= steps[i].dst;
            out_ready_i     <= steps[i].out_ready;
            retire_i        <= steps[i].retire;
            flush_i         <= steps[i].flush;
            @(negedge clk);
            model_cycle(steps[i]);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("output register still held a bundle after the final idle steps");
        end
        if (!full_seen) begin
            errors++;
            $display("the ROB never reached the full condition");
        end
        $display("checks done over %0d steps, %0d errors", steps.size(), errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((steps.size() + 10) * 20 + 200);
        $display("timeout, the step table did not complete in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
design/rename_pkg.sv
design/rename_ifs.sv
design/rename_rat.sv
design/rob_alloc.sv
design/rename_stage.sv
design/rename_top.sv
verification/rename_checker.sv
verification/tb_rename_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_rename_top
RTL_TOP    = rename_top
FILELIST   = compile.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint lint_rtl build sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) $(LINT_FLAGS) design/rename_pkg.sv design/rename_ifs.sv \
		design/rename_rat.sv design/rob_alloc.sv design/rename_stage.sv \
		design/rename_top.sv --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
